// File: files.f
verilog/pcie_phy_pkg.sv
verilog/phy_receive.sv
verilog/phy_transmit.sv
verilog/pcie_ltssm_downstream.sv
verilog/pcie_phy_top.sv
sim/tb_clock_gen.sv
sim/pcie_phy_tb.sv

// File: run.sh
#!/bin/sh
# Builds and runs the PCIe PHY testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module pcie_phy_tb -f files.f -o pcie_phy_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/pcie_phy_sim)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Regression passed"; then
  exit 0
fi
exit 1

// File: sim/pcie_phy_tb.sv
`timescale 1ns/1ps

module pcie_phy_tb;

  localparam int LANES = 4;
  localparam logic [7:0] COM = 8'hBC;
  localparam logic [7:0] IDL = 8'h7C;
  localparam logic [7:0] TS1 = 8'h4A;
  localparam logic [7:0] TS2 = 8'h45;
  localparam logic [2:0] DETECTED = 3'b011;
  localparam logic [31:0] IDLE_WORD = {IDL, IDL, IDL, COM};
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  typedef enum int {
    RESET_VALUES, DETECT_NO_LANE0, DETECT_TS1, TRAIN_TO_L0, DATA_BOTH_WAYS, LINK_LOSS
  } test_kind_e;

  typedef struct {
    string            name;
    test_kind_e       kind;
    logic [LANES-1:0] present;
    logic [LANES-1:0] exp_lanes;
    int               count;
  } test_entry_t;

  logic clk;
  logic rst;
  logic en;
  logic link_up;
  pcie_phy_pkg::ltssm_state_e state;
  logic [LANES-1:0][31:0] tx_data;
  logic [LANES-1:0][3:0]  tx_k;
  logic [LANES-1:0]       tx_valid;
  logic [LANES-1:0]       tx_elecidle;
  logic                   tx_detect;
  logic [LANES-1:0][31:0] rx_data;
  logic [LANES-1:0][3:0]  rx_k;
  logic [LANES-1:0]       rx_valid;
  logic [LANES-1:0]       phystatus;
  logic [LANES-1:0][2:0]  rxstatus;
  logic [LANES-1:0]       rx_elecidle;
  logic [LANES-1:0][31:0] s_data;
  logic                   s_valid;
  logic [LANES-1:0][31:0] m_data;
  logic                   m_valid;

  logic [31:0] lfsr_state;
  int          check_count;
  int          error_count;
  int          ts_seen;
  string       cur_name;
  test_entry_t tests [6];

  tb_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(8)) clock_gen_i (.clk_o(clk), .rst_o(rst));

  pcie_phy_top #(.MAX_NUM_LANES(LANES)) pcie_phy_top_i (
    .clk_i(clk), .rst_i(rst), .en_i(en), .link_up_o(link_up), .ltssm_state_o(state),
    .phy_txdata_o(tx_data), .phy_txdatak_o(tx_k), .phy_txdata_valid_o(tx_valid),
    .phy_txelecidle_o(tx_elecidle), .phy_txdetectrx_o(tx_detect),
    .phy_rxdata_i(rx_data), .phy_rxdatak_i(rx_k), .phy_rxdata_valid_i(rx_valid),
    .phy_phystatus_i(phystatus), .phy_rxstatus_i(rxstatus), .phy_rxelecidle_i(rx_elecidle),
    .s_data_i(s_data), .s_valid_i(s_valid), .m_data_o(m_data), .m_valid_o(m_valid)
  );

  function automatic logic [31:0] ts_word(input logic [7:0] id, input int lane);
    return {id, id, 8'(lane), COM};
  endfunction

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] bits);
    bits = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_state = lfsr_step(lfsr_state);
      bits = {bits[30:0], lfsr_state[0]};
    end
  endtask

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    check_count++;
    assert (act == exp) else begin
      $display("Fail %s %s: expected %h, actual %h", cur_name, what, exp, act);
      error_count++;
    end
  endtask

  task automatic check_at_least(input string what, input int min, input int act);
    check_count++;
    assert (act >= min) else begin
      $display("Fail %s %s: expected at least %0d, actual %0d", cur_name, what, min, act);
      error_count++;
    end
  endtask

  task automatic check_true(input logic cond, input string text);
    check_count++;
    assert (cond) else begin
      $display("%s: %s", cur_name, text);
      error_count++;
    end
  endtask

  // Steps falling edges until txdetectrx, counting lane 0 words meanwhile
  task automatic wait_detect(output logic seen, output int lane0_words);
    int n;
    n = 0;
    lane0_words = 0;
    while (!tx_detect && n < 100) begin
      @(negedge clk);
      n++;
      if (tx_valid[0]) lane0_words++;
    end
    seen = tx_detect;
  endtask

  task automatic answer_detect(input logic [LANES-1:0] present);
    phystatus = '1;
    for (int i = 0; i < LANES; i++) begin
      rxstatus[i] = present[i] ? DETECTED : 3'b000;
    end
    @(negedge clk);
    phystatus = '0;
    rxstatus  = '0;
  endtask

  // TS words, or idle words when id is IDL
  task automatic set_partner(input logic [LANES-1:0] lanes, input logic [7:0] id);
    for (int i = 0; i < LANES; i++) begin
      rx_valid[i] = lanes[i];
      rx_data[i]  = (id == IDL) ? IDLE_WORD : ts_word(id, i);
      rx_k[i]     = (id == IDL) ? 4'hF : 4'h1;
    end
  endtask

  task automatic check_reset_values();
    int n;
    n = 0;
    while (rst && n < 20) begin
      @(negedge clk);
      n++;
    end
    check_true(!rst, "reset was never released");
    @(negedge clk);
    check_value("link_up", 32'd0, 32'(link_up));
    check_value("m_valid", 32'd0, 32'(m_valid));
    check_value("txdetectrx", 32'd0, 32'(tx_detect));
    check_value("tx valid", 32'd0, 32'(tx_valid));
    check_value("tx elecidle", 32'hF, 32'(tx_elecidle));
    check_value("state", 32'(pcie_phy_pkg::DETECT_QUIET), 32'(state));
  endtask

  task automatic detect_without_lane0(input logic [LANES-1:0] present);
    logic seen;
    int   words;
    en = 1'b1;
    wait_detect(seen, words);
    check_true(seen, "no txdetectrx pulse after enable");
    answer_detect(present);
    check_value("state", 32'(pcie_phy_pkg::DETECT_QUIET), 32'(state));
    wait_detect(seen, words);
    check_true(seen, "no second txdetectrx pulse");
    check_value("lane 0 words", 32'd0, 32'(words));
  endtask

  task automatic detect_and_ts1(input logic [LANES-1:0] present, input logic [LANES-1:0] lanes);
    logic seen;
    int   words;
    int   n;
    wait_detect(seen, words);
    check_true(seen, "no txdetectrx pulse to answer");
    answer_detect(present);
    n = 0;
    while (!tx_valid[0] && n < 20) begin
      @(negedge clk);
      n++;
    end
    check_true(tx_valid[0], "timed out waiting for TS1 on lane 0");
    for (int i = 0; i < LANES; i++) begin
      check_value($sformatf("lane %0d valid", i), 32'(lanes[i]), 32'(tx_valid[i]));
      check_value($sformatf("lane %0d elecidle", i), 32'(!lanes[i]), 32'(tx_elecidle[i]));
      if (lanes[i]) begin
        check_value($sformatf("lane %0d data", i), ts_word(TS1, i), tx_data[i]);
        check_value($sformatf("lane %0d k", i), 32'h1, 32'(tx_k[i]));
      end
    end
    ts_seen = 1;
  endtask

  task automatic train_to_l0(input logic [LANES-1:0] lanes, input int min);
    int   ts1_words;
    int   ts2_words;
    int   n;
    logic switched;
    ts1_words = ts_seen;
    switched  = 1'b0;
    n = 0;
    set_partner(lanes, TS1);
    while (!switched && n < 400) begin
      @(negedge clk);
      n++;
      if (tx_valid[0] && tx_data[0] == ts_word(TS1, 0)) ts1_words++;
      switched = tx_valid[0] && tx_data[0] == ts_word(TS2, 0);
    end
    check_true(switched, "timed out waiting for TS2 from the DUT");
    check_at_least("TS1 words before TS2", min, ts1_words);
    set_partner(lanes, TS2);
    ts2_words = 1;
    n = 0;
    while (!link_up && n < 400) begin
      @(negedge clk);
      n++;
      if (tx_valid[0] && tx_data[0] == ts_word(TS2, 0)) ts2_words++;
    end
    check_true(link_up, "timed out waiting for link up");
    check_at_least("TS2 words before link up", min, ts2_words);
    set_partner(lanes, IDL);
  endtask

  task automatic check_data_cycle(input logic [LANES-1:0] lanes, input logic sv,
                                  input logic [LANES-1:0][31:0] sd, input logic rd,
                                  input logic [LANES-1:0][31:0] rw);
    for (int i = 0; i < LANES; i++) begin
      check_value($sformatf("tx lane %0d valid", i), 32'(lanes[i]), 32'(tx_valid[i]));
      if (lanes[i]) begin
        check_value($sformatf("tx lane %0d data", i), sv ? sd[i] : IDLE_WORD, tx_data[i]);
        check_value($sformatf("tx lane %0d k", i), sv ? 32'h0 : 32'hF, 32'(tx_k[i]));
      end
      check_value($sformatf("rx lane %0d data", i), (rd && lanes[i]) ? rw[i] : 32'h0, m_data[i]);
    end
    check_value("m_valid", 32'(rd), 32'(m_valid));
  endtask

  task automatic data_both_ways(input logic [LANES-1:0] lanes, input int count);
    logic [LANES-1:0][31:0] sd;
    logic [LANES-1:0][31:0] rw;
    logic [31:0]            bits;
    logic                   sv;
    logic                   rd;
    for (int c = 0; c <= count; c++) begin
      if (c > 0) check_data_cycle(lanes, sv, sd, rd, rw);
      if (c < count) begin
        // First cycle carries data, the second idles
        take_bits(1, bits);
        sv = (c == 0) || (c != 1 && bits[0]);
        take_bits(1, bits);
        rd = (c == 0) || (c != 1 && bits[0]);
        for (int i = 0; i < LANES; i++) begin
          take_bits(32, bits);
          sd[i] = bits;
          take_bits(32, bits);
          rw[i] = bits;
          rx_valid[i] = 1'b1;
          rx_data[i]  = rd ? rw[i] : IDLE_WORD;
          rx_k[i]     = rd ? 4'h0 : 4'hF;
        end
        s_data  = sd;
        s_valid = sv;
        @(negedge clk);
      end
    end
    s_valid = 1'b0;
    set_partner(lanes, IDL);
  endtask

  task automatic lose_link();
    logic seen;
    int   words;
    int   n;
    rx_elecidle[0] = 1'b1;
    rx_valid = '0;
    n = 0;
    while (link_up && n < 20) begin
      @(negedge clk);
      n++;
    end
    check_true(!link_up, "link_up_o stayed high after electrical idle");
    check_value("state", 32'(pcie_phy_pkg::DETECT_QUIET), 32'(state));
    wait_detect(seen, words);
    check_true(seen, "no txdetectrx pulse after link loss");
  endtask

  task automatic add_test(input int idx, input string name, input test_kind_e kind,
                          input logic [LANES-1:0] present, input logic [LANES-1:0] exp_lanes,
                          input int count);
    tests[idx].name      = name;
    tests[idx].kind      = kind;
    tests[idx].present   = present;
    tests[idx].exp_lanes = exp_lanes;
    tests[idx].count     = count;
  endtask

  initial begin
    int errors_before;
    en = 1'b0;
    s_valid = 1'b0;
    s_data = '0;
    rx_data = '0;
    rx_k = '0;
    rx_valid = '0;
    phystatus = '0;
    rxstatus = '0;
    rx_elecidle = '0;
    lfsr_state = 32'h5efd_c07f;
    check_count = 0;
    error_count = 0;
    ts_seen = 0;
    add_test(0, "reset", RESET_VALUES, 4'b0000, 4'b0000, 0);
    add_test(1, "detect_no_lane0", DETECT_NO_LANE0, 4'b0110, 4'b0000, 0);
    // Lane 3 sits above the gap at lane 2
    add_test(2, "detect_ts1", DETECT_TS1, 4'b1011, 4'b0011, 0);
    add_test(3, "train_to_l0", TRAIN_TO_L0, 4'b0000, 4'b0011, 16);
    add_test(4, "data_both_ways", DATA_BOTH_WAYS, 4'b0000, 4'b0011, 12);
    add_test(5, "link_loss", LINK_LOSS, 4'b0000, 4'b0000, 0);
    for (int t = 0; t < 6; t++) begin
      cur_name = tests[t].name;
      errors_before = error_count;
      case (tests[t].kind)
        RESET_VALUES:    check_reset_values();
        DETECT_NO_LANE0: detect_without_lane0(tests[t].present);
        DETECT_TS1:      detect_and_ts1(tests[t].present, tests[t].exp_lanes);
        TRAIN_TO_L0:     train_to_l0(tests[t].exp_lanes, tests[t].count);
        DATA_BOTH_WAYS:  data_both_ways(tests[t].exp_lanes, tests[t].count);
        default:         lose_link();
      endcase
      $display("test %s: %s", cur_name, (error_count == errors_before) ? "ok" : "errors");
    end
    $display("6 tests, %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: sim/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 8
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Released on a falling edge, away from the active edge
  initial begin
    rst_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;
  end

endmodule

// File: verilog/pcie_ltssm_downstream.sv
`timescale 1ns/1ps

module pcie_ltssm_downstream #(
  parameter int MAX_NUM_LANES = 4
) (
  input  logic                                        clk_i,
  input  logic                                        rst_i,
  input  logic                                        en_i,
  input  logic                   [MAX_NUM_LANES-1:0]  phy_phystatus_i,
  input  logic [MAX_NUM_LANES-1:0][2:0]               phy_rxstatus_i,
  input  logic                   [MAX_NUM_LANES-1:0]  phy_rxelecidle_i,
  input  pcie_phy_pkg::rx_lane_t [MAX_NUM_LANES-1:0]  rx_lanes_i,
  input  logic                                        os_sent_i,
  output logic                                        phy_txdetectrx_o,
  output logic                   [MAX_NUM_LANES-1:0]  active_lanes_o,
  output pcie_phy_pkg::os_kind_e                      tx_os_kind_o,
  output logic                                        link_up_o,
  output pcie_phy_pkg::ltssm_state_e                  ltssm_state_o
);

  localparam int DETECT_TIMEOUT = 1000;
  localparam int TIMER_W        = $clog2(DETECT_TIMEOUT);
  localparam int RX_OK_TARGET   = 8;
  localparam int TX_TARGET      = 16;
  localparam int RX_CNT_W       = $clog2(RX_OK_TARGET + 1);
  localparam int TX_CNT_W       = $clog2(TX_TARGET + 1);

  pcie_phy_pkg::ltssm_state_e state;
  pcie_phy_pkg::ltssm_state_e state_next;
  logic                       entry_q;
  logic [TIMER_W-1:0]         detect_timer;
  logic                       detect_timeout;
  logic [RX_CNT_W-1:0]        rx_ok_cnt;
  logic [TX_CNT_W-1:0]        tx_cnt;
  logic [MAX_NUM_LANES-1:0]   detect_mask;
  logic [MAX_NUM_LANES-1:0]   lane_ok;
  logic                       lanes_ok;
  logic                       training_done;

  // Contiguous run of detected lanes from lane 0
  always_comb begin
    logic run;
    run = 1'b1;
    for (int i = 0; i < MAX_NUM_LANES; i++) begin
      run = run && phy_phystatus_i[i] &&
            phy_rxstatus_i[i] == pcie_phy_pkg::RXSTATUS_DETECTED;
      detect_mask[i] = run;
    end
  end

  // TS2 only in Polling.Configuration
  always_comb begin
    for (int i = 0; i < MAX_NUM_LANES; i++) begin
      lane_ok[i] = (rx_lanes_i[i].kind == pcie_phy_pkg::OS_TS2) ||
                   (rx_lanes_i[i].kind == pcie_phy_pkg::OS_TS1 &&
                    state != pcie_phy_pkg::POLLING_CONFIG);
    end
  end

  assign lanes_ok       = (|active_lanes_o) && ((lane_ok | ~active_lanes_o) == '1);
  assign detect_timeout = detect_timer == TIMER_W'(DETECT_TIMEOUT - 1);
  assign training_done  = rx_ok_cnt == RX_CNT_W'(RX_OK_TARGET) && tx_cnt == TX_CNT_W'(TX_TARGET);

  always_comb begin
    state_next = state;
    case (state)
      pcie_phy_pkg::DETECT_QUIET: begin
        if (en_i) state_next = pcie_phy_pkg::DETECT_ACTIVE;
      end
      pcie_phy_pkg::DETECT_ACTIVE: begin
        if (|phy_phystatus_i) begin
          state_next = detect_mask[0] ? pcie_phy_pkg::POLLING_ACTIVE : pcie_phy_pkg::DETECT_QUIET;
        end else if (detect_timeout) begin
          state_next = pcie_phy_pkg::DETECT_QUIET;
        end
      end
      pcie_phy_pkg::POLLING_ACTIVE: begin
        if (training_done) state_next = pcie_phy_pkg::POLLING_CONFIG;
      end
      pcie_phy_pkg::POLLING_CONFIG: begin
        if (training_done) state_next = pcie_phy_pkg::L0;
      end
      pcie_phy_pkg::L0: begin
        if (phy_rxelecidle_i[0] || !en_i) state_next = pcie_phy_pkg::DETECT_QUIET;
      end
      default: state_next = pcie_phy_pkg::DETECT_QUIET;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state          <= pcie_phy_pkg::DETECT_QUIET;
      entry_q        <= 1'b0;
      active_lanes_o <= '0;
      detect_timer   <= '0;
      rx_ok_cnt      <= '0;
      tx_cnt         <= '0;
    end else begin
      state   <= state_next;
      entry_q <= state_next != state;
      if (state == pcie_phy_pkg::DETECT_QUIET) begin
        active_lanes_o <= '0;
      end else if (state == pcie_phy_pkg::DETECT_ACTIVE && |phy_phystatus_i) begin
        active_lanes_o <= detect_mask;
      end
      if (state == pcie_phy_pkg::DETECT_ACTIVE && state_next == pcie_phy_pkg::DETECT_ACTIVE) begin
        detect_timer <= detect_timer + 1'b1;
      end else begin
        detect_timer <= '0;
      end
      if (state_next != state) begin
        rx_ok_cnt <= '0;
        tx_cnt    <= '0;
      end else begin
        if (!lanes_ok) begin
          rx_ok_cnt <= '0;
        end else if (rx_ok_cnt != RX_CNT_W'(RX_OK_TARGET)) begin
          rx_ok_cnt <= rx_ok_cnt + 1'b1;
        end
        // First pulse of a state belongs to the previous request
        if (os_sent_i && !entry_q && tx_cnt != TX_CNT_W'(TX_TARGET)) begin
          tx_cnt <= tx_cnt + 1'b1;
        end
      end
    end
  end

  always_comb begin
    case (state)
      pcie_phy_pkg::POLLING_ACTIVE: tx_os_kind_o = pcie_phy_pkg::OS_TS1;
      pcie_phy_pkg::POLLING_CONFIG: tx_os_kind_o = pcie_phy_pkg::OS_TS2;
      pcie_phy_pkg::L0:             tx_os_kind_o = pcie_phy_pkg::OS_DATA;
      default:                      tx_os_kind_o = pcie_phy_pkg::OS_NONE;
    endcase
  end

  assign phy_txdetectrx_o = entry_q && state == pcie_phy_pkg::DETECT_ACTIVE;
  assign link_up_o        = state == pcie_phy_pkg::L0;
  assign ltssm_state_o    = state;

  // Detection pulse marks the move out of Detect.Quiet with the port enabled
  assert property (@(posedge clk_i) disable iff (rst_i)
    phy_txdetectrx_o |-> $past(state) == pcie_phy_pkg::DETECT_QUIET && $past(en_i))
    else $error("pcie_ltssm_downstream: txdetectrx without entry into Detect.Active");

endmodule

// File: verilog/pcie_phy_pkg.sv
package pcie_phy_pkg;

  // PIPE symbol and lane word
  typedef logic [7:0]  symbol_t;
  typedef logic [31:0] lane_word_t;
  typedef logic [3:0]  lane_k_t;

  // 8b/10b control symbols
  localparam symbol_t COM_SYM = 8'hBC;
  localparam symbol_t IDL_SYM = 8'h7C;

  // Training set identifiers
  localparam symbol_t TS1_ID = 8'h4A;
  localparam symbol_t TS2_ID = 8'h45;

  // Receiver present, reported with phystatus
  localparam logic [2:0] RXSTATUS_DETECTED = 3'b011;

  // K flag patterns of the single-word ordered sets
  localparam lane_k_t TS_K_FLAGS   = 4'b0001;
  localparam lane_k_t IDLE_K_FLAGS = 4'b1111;
  localparam lane_k_t DATA_K_FLAGS = 4'b0000;

  // Symbol 0 in the low byte
  localparam lane_word_t IDLE_WORD = {IDL_SYM, IDL_SYM, IDL_SYM, COM_SYM};

  typedef enum logic [2:0] {
    OS_NONE = 3'd0,
    OS_TS1  = 3'd1,
    OS_TS2  = 3'd2,
    OS_IDLE = 3'd3,
    OS_DATA = 3'd4
  } os_kind_e;

  typedef enum logic [2:0] {
    DETECT_QUIET   = 3'd0,
    DETECT_ACTIVE  = 3'd1,
    POLLING_ACTIVE = 3'd2,
    POLLING_CONFIG = 3'd3,
    L0             = 3'd4
  } ltssm_state_e;

  // What one lane received, with symbol 1 as lane number
  typedef struct packed {
    os_kind_e kind;
    symbol_t  lane_num;
  } rx_lane_t;

  typedef struct packed {
    lane_word_t data;
    lane_k_t    datak;
    logic       valid;
    logic       elecidle;
  } pipe_tx_lane_t;

endpackage

// File: verilog/pcie_phy_top.sv
`timescale 1ns/1ps

module pcie_phy_top #(
  parameter int MAX_NUM_LANES = 4
) (
  input  logic                                          clk_i,
  input  logic                                          rst_i,
  input  logic                                          en_i,
  output logic                                          link_up_o,
  output pcie_phy_pkg::ltssm_state_e                    ltssm_state_o,
  // PIPE transmit
  output pcie_phy_pkg::lane_word_t [MAX_NUM_LANES-1:0] phy_txdata_o,
  output pcie_phy_pkg::lane_k_t    [MAX_NUM_LANES-1:0] phy_txdatak_o,
  output logic                     [MAX_NUM_LANES-1:0] phy_txdata_valid_o,
  output logic                     [MAX_NUM_LANES-1:0] phy_txelecidle_o,
  output logic                                          phy_txdetectrx_o,
  // PIPE receive
  input  pcie_phy_pkg::lane_word_t [MAX_NUM_LANES-1:0] phy_rxdata_i,
  input  pcie_phy_pkg::lane_k_t    [MAX_NUM_LANES-1:0] phy_rxdatak_i,
  input  logic                     [MAX_NUM_LANES-1:0] phy_rxdata_valid_i,
  input  logic                     [MAX_NUM_LANES-1:0] phy_phystatus_i,
  input  logic [MAX_NUM_LANES-1:0][2:0]                 phy_rxstatus_i,
  input  logic                     [MAX_NUM_LANES-1:0] phy_rxelecidle_i,
  // User word bus
  input  pcie_phy_pkg::lane_word_t [MAX_NUM_LANES-1:0] s_data_i,
  input  logic                                          s_valid_i,
  output pcie_phy_pkg::lane_word_t [MAX_NUM_LANES-1:0] m_data_o,
  output logic                                          m_valid_o
);

  pcie_phy_pkg::rx_lane_t [MAX_NUM_LANES-1:0] rx_lanes;
  pcie_phy_pkg::os_kind_e                     tx_os_kind;
  logic                   [MAX_NUM_LANES-1:0] active_lanes;
  logic                                       os_sent;

  phy_receive #(
    .MAX_NUM_LANES(MAX_NUM_LANES)
  ) phy_receive_i (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .pipe_data_i      (phy_rxdata_i),
    .pipe_data_k_i    (phy_rxdatak_i),
    .pipe_data_valid_i(phy_rxdata_valid_i),
    .link_up_i        (link_up_o),
    .active_lanes_i   (active_lanes),
    .rx_lanes_o       (rx_lanes),
    .m_data_o         (m_data_o),
    .m_valid_o        (m_valid_o)
  );

  phy_transmit #(
    .MAX_NUM_LANES(MAX_NUM_LANES)
  ) phy_transmit_i (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .tx_os_kind_i     (tx_os_kind),
    .active_lanes_i   (active_lanes),
    .link_up_i        (link_up_o),
    .s_data_i         (s_data_i),
    .s_valid_i        (s_valid_i),
    .pipe_data_o      (phy_txdata_o),
    .pipe_data_k_o    (phy_txdatak_o),
    .pipe_data_valid_o(phy_txdata_valid_o),
    .pipe_elecidle_o  (phy_txelecidle_o),
    .os_sent_o        (os_sent)
  );

  pcie_ltssm_downstream #(
    .MAX_NUM_LANES(MAX_NUM_LANES)
  ) pcie_ltssm_downstream_i (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .en_i            (en_i),
    .phy_phystatus_i (phy_phystatus_i),
    .phy_rxstatus_i  (phy_rxstatus_i),
    .phy_rxelecidle_i(phy_rxelecidle_i),
    .rx_lanes_i      (rx_lanes),
    .os_sent_i       (os_sent),
    .phy_txdetectrx_o(phy_txdetectrx_o),
    .active_lanes_o  (active_lanes),
    .tx_os_kind_o    (tx_os_kind),
    .link_up_o       (link_up_o),
    .ltssm_state_o   (ltssm_state_o)
  );

endmodule

// File: verilog/phy_receive.sv
`timescale 1ns/1ps

module phy_receive #(
  parameter int MAX_NUM_LANES = 4
) (
  input  logic                                          clk_i,
  input  logic                                          rst_i,
  input  pcie_phy_pkg::lane_word_t [MAX_NUM_LANES-1:0] pipe_data_i,
  input  pcie_phy_pkg::lane_k_t    [MAX_NUM_LANES-1:0] pipe_data_k_i,
  input  logic                     [MAX_NUM_LANES-1:0] pipe_data_valid_i,
  input  logic                                          link_up_i,
  input  logic                     [MAX_NUM_LANES-1:0] active_lanes_i,
  output pcie_phy_pkg::rx_lane_t   [MAX_NUM_LANES-1:0] rx_lanes_o,
  output pcie_phy_pkg::lane_word_t [MAX_NUM_LANES-1:0] m_data_o,
  output logic                                          m_valid_o
);

  pcie_phy_pkg::os_kind_e rx_kind [MAX_NUM_LANES];

  // Sort one word by its K flags and symbols
  function automatic pcie_phy_pkg::os_kind_e classify(
    input pcie_phy_pkg::lane_word_t word,
    input pcie_phy_pkg::lane_k_t    k
  );
    pcie_phy_pkg::symbol_t  sym0;
    pcie_phy_pkg::symbol_t  sym2;
    pcie_phy_pkg::symbol_t  sym3;
    pcie_phy_pkg::os_kind_e kind;
    sym0 = word[7:0];
    sym2 = word[23:16];
    sym3 = word[31:24];
    kind = pcie_phy_pkg::OS_NONE;
    if (k == pcie_phy_pkg::DATA_K_FLAGS) begin
      kind = pcie_phy_pkg::OS_DATA;
    end else if (k == pcie_phy_pkg::TS_K_FLAGS && sym0 == pcie_phy_pkg::COM_SYM &&
                 sym2 == sym3) begin
      // TS identifier repeated in symbols 2 and 3
      if (sym2 == pcie_phy_pkg::TS1_ID) begin
        kind = pcie_phy_pkg::OS_TS1;
      end else if (sym2 == pcie_phy_pkg::TS2_ID) begin
        kind = pcie_phy_pkg::OS_TS2;
      end
    end else if (k == pcie_phy_pkg::IDLE_K_FLAGS && word == pcie_phy_pkg::IDLE_WORD) begin
      kind = pcie_phy_pkg::OS_IDLE;
    end
    return kind;
  endfunction

  always_comb begin
    for (int i = 0; i < MAX_NUM_LANES; i++) begin
      if (pipe_data_valid_i[i]) begin
        rx_kind[i] = classify(pipe_data_i[i], pipe_data_k_i[i]);
      end else begin
        rx_kind[i] = pcie_phy_pkg::OS_NONE;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rx_lanes_o <= '0;
      m_valid_o  <= 1'b0;
    end else begin
      for (int i = 0; i < MAX_NUM_LANES; i++) begin
        rx_lanes_o[i].kind     <= rx_kind[i];
        rx_lanes_o[i].lane_num <= pipe_data_i[i][15:8];
      end
      // Lane 0 data marks a user word
      m_valid_o <= link_up_i && active_lanes_i[0] && rx_kind[0] == pcie_phy_pkg::OS_DATA;
    end
  end

  // Inactive or non-data lanes read as zero
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < MAX_NUM_LANES; i++) begin
      if (link_up_i && active_lanes_i[i] && rx_kind[i] == pcie_phy_pkg::OS_DATA) begin
        m_data_o[i] <= pipe_data_i[i];
      end else begin
        m_data_o[i] <= '0;
      end
    end
  end

  assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(m_valid_o) |-> $past(link_up_i))
    else $error("phy_receive: m_valid_o rose while the link was down");

endmodule

// File: verilog/phy_transmit.sv
`timescale 1ns/1ps

module phy_transmit #(
  parameter int MAX_NUM_LANES = 4
) (
  input  logic                                          clk_i,
  input  logic                                          rst_i,
  input  pcie_phy_pkg::os_kind_e                        tx_os_kind_i,
  input  logic                     [MAX_NUM_LANES-1:0] active_lanes_i,
  input  logic                                          link_up_i,
  input  pcie_phy_pkg::lane_word_t [MAX_NUM_LANES-1:0] s_data_i,
  input  logic                                          s_valid_i,
  output pcie_phy_pkg::lane_word_t [MAX_NUM_LANES-1:0] pipe_data_o,
  output pcie_phy_pkg::lane_k_t    [MAX_NUM_LANES-1:0] pipe_data_k_o,
  output logic                     [MAX_NUM_LANES-1:0] pipe_data_valid_o,
  output logic                     [MAX_NUM_LANES-1:0] pipe_elecidle_o,
  output logic                                          os_sent_o
);

  pcie_phy_pkg::pipe_tx_lane_t tx_next [MAX_NUM_LANES];
  logic                        ts_request;
  pcie_phy_pkg::symbol_t       ts_id;

  assign ts_request = (tx_os_kind_i == pcie_phy_pkg::OS_TS1) ||
                      (tx_os_kind_i == pcie_phy_pkg::OS_TS2);
  assign ts_id = (tx_os_kind_i == pcie_phy_pkg::OS_TS2) ? pcie_phy_pkg::TS2_ID
                                                         : pcie_phy_pkg::TS1_ID;

  always_comb begin
    for (int i = 0; i < MAX_NUM_LANES; i++) begin
      tx_next[i]          = '0;
      tx_next[i].elecidle = 1'b1;
      if (!active_lanes_i[i]) begin
        // Stays in electrical idle
        tx_next[i].elecidle = 1'b1;
      end else if (ts_request) begin
        tx_next[i].data = {ts_id, ts_id, pcie_phy_pkg::symbol_t'(i), pcie_phy_pkg::COM_SYM};
        tx_next[i].datak    = pcie_phy_pkg::TS_K_FLAGS;
        tx_next[i].valid    = 1'b1;
        tx_next[i].elecidle = 1'b0;
      end else if (tx_os_kind_i != pcie_phy_pkg::OS_NONE) begin
        if (tx_os_kind_i == pcie_phy_pkg::OS_DATA && link_up_i && s_valid_i) begin
          tx_next[i].data  = s_data_i[i];
          tx_next[i].datak = pcie_phy_pkg::DATA_K_FLAGS;
        end else begin
          // Idle fills cycles without user data
          tx_next[i].data  = pcie_phy_pkg::IDLE_WORD;
          tx_next[i].datak = pcie_phy_pkg::IDLE_K_FLAGS;
        end
        tx_next[i].valid    = 1'b1;
        tx_next[i].elecidle = 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pipe_data_valid_o <= '0;
      pipe_elecidle_o   <= '1;
      os_sent_o         <= 1'b0;
    end else begin
      for (int i = 0; i < MAX_NUM_LANES; i++) begin
        pipe_data_valid_o[i] <= tx_next[i].valid;
        pipe_elecidle_o[i]   <= tx_next[i].elecidle;
      end
      // Pulses with each TS word on lane 0
      os_sent_o <= tx_next[0].valid && ts_request;
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < MAX_NUM_LANES; i++) begin
      pipe_data_o[i]   <= tx_next[i].data;
      pipe_data_k_o[i] <= tx_next[i].datak;
    end
  end

  for (genvar g = 0; g < MAX_NUM_LANES; g++) begin : g_lane_check
    assert property (@(posedge clk_i) disable iff (rst_i)
      (pipe_data_valid_o[g] && pipe_data_k_o[g] == pcie_phy_pkg::DATA_K_FLAGS)
        |-> $past(link_up_i))
      else $error("phy_transmit: data word on lane %0d with the link down", g);
  end

endmodule
